/* excm_patterns.txt */
# kind name jump_addr pcr ppcr_in idtr psr irq_num fi0r irq_lock ldst_lock exp_pc exp_ppcr
# All hex; interrupt exp_pc is (idtr + irq_num*8 + 4) XOR 5a5a0000
JMP jump_basic    00001000 00000000 00000000 00000000 00000004 00 00000000 0 0 00001000 00000000
JMP jump_high     8000fffc 00000000 00000000 00000000 00000004 00 00000000 0 0 8000fffc 00000000
JMP jump_zero     00000000 00000000 00000000 00000000 00000004 00 00000000 0 0 00000000 00000000
IRQ irq_num0      00000000 00002000 00000000 00010000 00000004 00 11110000 0 0 5a5b0004 00002000
IRQ irq_num5      00000000 00003004 00000000 00010000 00000004 05 22220000 0 0 5a5b002c 00003004
IRQ irq_num127    00000000 0000a000 00000000 00020000 00000004 7f 33330000 0 0 5a5803fc 0000a000
IRQ irq_base_hi   00000000 12345678 00000000 ffff0000 00000004 10 44440000 0 0 a5a50084 12345678
IRQ irq_carry     00000000 00000100 00000000 0000fff0 00000004 02 55550000 0 0 5a5b0004 00000100
IRQ irq_psr_all   00000000 0000beef 00000000 40000000 ffffffff 01 66660000 0 0 1a5a000c 0000beef
MSK msk_lock      00000000 00002000 00000000 00010000 00000004 03 00000000 1 0 00000000 00000000
MSK msk_psr_off   00000000 00002000 00000000 00010000 00000000 03 00000000 0 0 00000000 00000000
MSK msk_psr_bits  00000000 00002000 00000000 00010000 fffffffb 03 00000000 0 0 00000000 00000000
IJP ijp_basic     00004000 00003ff0 00000000 00010000 00000004 03 77770000 0 0 5a5b001c 00004000
IJP ijp_irq_lock  00008000 00000500 00000000 00030000 00000004 0a 88880000 1 0 5a590054 00008000
IJP ijp_high      fffffff0 00000700 00000000 00000000 00000004 7f 99990000 0 0 5a5a03fc fffffff0
JLK jlk_ldst_lock 00005000 00000000 00000000 00010000 00000004 01 00000000 0 1 00005000 00000000
JLK jlk_psr_off   00006000 00000000 00000000 00010000 00000000 01 00000000 0 0 00006000 00000000
RET ret_basic     00000000 00000000 00002000 00000000 00000004 00 00000000 0 0 00002000 00000000
RET ret_high      00000000 00000000 c0000010 00000000 00000004 00 00000000 0 0 c0000010 00000000
IRQ irq_after_ret 00000000 00000040 00000000 00000100 00000004 02 aaaa0000 0 0 5a5a0114 00000040
TSW tsw_basic     00007000 00000000 00000000 00000000 00000004 00 00000000 0 0 00007000 00000000
TSW tsw_high      fffffff0 00000000 00000000 00000000 00000004 00 00000000 0 0 fffffff0 00000000

/* project.f */
+incdir+.
excm_pkg.sv
idt_fetch_if.sv
idt_vector_reader.sv
exception_sequencer.sv
exception_manager.sv
exception_manager_tb.sv

/* run.sh */
#!/bin/sh
# Builds the exception manager testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f project.f --top-module exception_manager_tb -o excm_sim
./obj_dir/excm_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
if grep -q "Result: FAILED" sim.log; then
	exit 1
fi
exit 0

/* exception_manager_tb.sv */
// Self-checking testbench for the exception manager driven by vectors from the pattern file
`timescale 1ns/1ps
`default_nettype none

`include "excm_params.svh"

module exception_manager_tb;

	logic iCLOCK;
	logic inRESET;
	logic jump, irq_ret, table_switch, irq_req, irq_lock, ldst_lock;
	logic [`EXCM_DATA_W-1:0] jump_addr, irq_fi0r, psr, pcr, ppcr_in, idtr;
	logic [`EXCM_IRQ_NUM_W-1:0] irq_num;
	logic irq_ack, register_lock, pipeline_stop, refresh, pc_set, ppcr_set, fi0r_set;
	logic set_irq_mode, clr_irq_mode, cache_flush, tlb_flush, ldst_use;
	logic [`EXCM_DATA_W-1:0] pc, ppcr, fi0r;
	logic ldst_req, ldst_busy, ldst_valid;
	logic [`EXCM_DATA_W-1:0] ldst_addr, ldst_data;

	// One pattern line
	logic [23:0] kind;
	logic [127:0] name;
	logic [31:0] p_jaddr, p_pcr, p_ppcr, p_idtr, p_psr, p_num, p_fi0r, p_ilock, p_llock;
	logic [31:0] exp_pc, exp_ppcr;
	string line;
	string tname;
	integer fd, nf, seed, err, pass_count, fail_count, edge_n;
	// Memory model state
	integer busy_left, resp_left, req_count;
	logic [31:0] last_addr;
	// What the DUT did during one event
	integer refresh_edge, ppcr_edge, mode_edge, flush_edge, pc_edge;
	logic [31:0] ppcr_seen, pc_seen, fi0r_seen;
	logic ack_seen, fi0r_set_seen, clr_seen;
	logic use_early, stop_early, use_end, lock_end;

	exception_manager dut0 (.*);

	always #10 iCLOCK = ~iCLOCK;

	// Load-store memory that answers with the address XOR a fixed mask
	always @(negedge iCLOCK) begin
		ldst_valid = 1'b0;
		if (resp_left > 0) begin
			resp_left = resp_left - 1;
			if (resp_left == 0) begin
				ldst_valid = 1'b1;
				ldst_data = last_addr ^ 32'h5a5a0000;
			end
		end
		if (busy_left > 0) begin
			busy_left = busy_left - 1;
			ldst_busy = 1'b1;
		end else if ({$random(seed)} % 4 == 0) begin
			// Busy bursts of one to three cycles
			busy_left = {$random(seed)} % 3;
			ldst_busy = 1'b1;
		end else begin
			ldst_busy = 1'b0;
		end
		#1;
		if (ldst_req) begin
			// Accepted at the coming rising edge
			req_count = req_count + 1;
			last_addr = ldst_addr;
			resp_left = 1 + {$random(seed)} % 4;
		end
	end

	task automatic check_val(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("MISMATCH test %0s %0s: expected %h, actual %h", tname, what,
				expected, actual);
			err = err + 1;
		end
	endtask

	task automatic report_test();
		if (err == 0) begin
			pass_count = pass_count + 1;
			$display("test %0s: pass", tname);
		end else begin
			fail_count = fail_count + 1;
			$display("test %0s: fail with %0d errors", tname, err);
		end
	endtask

	task automatic run_test();
		integer base;
		err = 0;
		base = req_count;
		edge_n = 0;
		refresh_edge = 0;
		ppcr_edge = 0;
		mode_edge = 0;
		flush_edge = 0;
		pc_edge = 0;
		jump_addr = p_jaddr;
		pcr = p_pcr;
		ppcr_in = p_ppcr;
		idtr = p_idtr;
		psr = p_psr;
		irq_num = p_num[`EXCM_IRQ_NUM_W-1:0];
		irq_fi0r = p_fi0r;
		irq_lock = p_ilock[0];
		ldst_lock = p_llock[0];
		jump = (kind == "JMP" || kind == "IJP" || kind == "JLK");
		irq_req = (kind == "IRQ" || kind == "IJP" || kind == "JLK" || kind == "MSK");
		irq_ret = (kind == "RET");
		table_switch = (kind == "TSW");
		if (kind == "MSK") begin
			// The core keeps running on a masked interrupt
			repeat (20) begin
				@(negedge iCLOCK);
				check_val("ppcr_set", 0, 32'(ppcr_set));
				check_val("irq_ack", 0, 32'(irq_ack));
				check_val("pipeline_stop", 0, 32'(pipeline_stop));
				check_val("ldst_use", 0, 32'(ldst_use));
			end
			irq_req = 1'b0;
		end else begin
			while (pc_edge == 0 && edge_n < 200) begin
				@(negedge iCLOCK);
				edge_n = edge_n + 1;
				if (edge_n == 1) begin
					use_early = ldst_use;
					stop_early = pipeline_stop;
					jump = 1'b0;
					irq_req = 1'b0;
					irq_ret = 1'b0;
					table_switch = 1'b0;
				end
				if (refresh && refresh_edge == 0) begin
					refresh_edge = edge_n;
				end
				if (ppcr_set && ppcr_edge == 0) begin
					ppcr_edge = edge_n;
					ppcr_seen = ppcr;
				end
				if (set_irq_mode && mode_edge == 0) begin
					mode_edge = edge_n;
				end
				if (cache_flush && tlb_flush && flush_edge == 0) begin
					flush_edge = edge_n;
				end
				if (pc_set) begin
					pc_edge = edge_n;
					pc_seen = pc;
					ack_seen = irq_ack;
					fi0r_set_seen = fi0r_set;
					fi0r_seen = fi0r;
					clr_seen = clr_irq_mode;
					use_end = ldst_use;
					lock_end = register_lock;
				end
			end
			if (pc_edge == 0) begin
				$display("TIMEOUT: test %0s got no pc_set within 200 cycles", tname);
				err = err + 1;
			end else if (kind == "IRQ" || kind == "IJP") begin
				// Behind a jump the entry starts one edge later
				check_val("ppcr_set edge", (kind == "IJP") ? 2 : 1, ppcr_edge);
				check_val("set_irq_mode edge", (kind == "IJP") ? 2 : 1, mode_edge);
				check_val("ppcr", exp_ppcr, ppcr_seen);
				check_val("ldst requests", 1, req_count - base);
				check_val("ldst_addr", exp_pc ^ 32'h5a5a0000, last_addr);
				check_val("pc", exp_pc, pc_seen);
				check_val("irq_ack", 1, 32'(ack_seen));
				check_val("fi0r_set", 1, 32'(fi0r_set_seen));
				check_val("fi0r", p_fi0r, fi0r_seen);
			end else if (kind == "RET") begin
				check_val("refresh edge", 1, refresh_edge);
				check_val("flush edge", 1, flush_edge);
				check_val("pc_set edge", 2, pc_edge);
				check_val("pc", exp_pc, pc_seen);
				check_val("clr_irq_mode", 1, 32'(clr_seen));
			end else begin
				// Jump, jump with refused interrupt, table switch
				check_val("refresh edge", 1, refresh_edge);
				check_val("pc_set edge", 2, pc_edge);
				check_val("pc", exp_pc, pc_seen);
				check_val("ppcr_set edge", 0, ppcr_edge);
				check_val("ldst requests", 0, req_count - base);
				check_val("irq_ack", 0, 32'(ack_seen));
			end
			if (pc_edge != 0) begin
				// Busy outputs while the event runs and in its last cycle
				check_val("ldst_use during event", 1, 32'(use_early));
				check_val("pipeline_stop during event", 1, 32'(stop_early));
				check_val("ldst_use with pc_set", 0, 32'(use_end));
				check_val("register_lock with pc_set", 1, 32'(lock_end));
			end
		end
		repeat (4) @(negedge iCLOCK);
		report_test();
	endtask

	initial begin
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		jump = 1'b0;
		irq_ret = 1'b0;
		table_switch = 1'b0;
		irq_req = 1'b0;
		irq_lock = 1'b0;
		ldst_lock = 1'b0;
		jump_addr = '0;
		irq_fi0r = '0;
		psr = '0;
		pcr = '0;
		ppcr_in = '0;
		idtr = '0;
		irq_num = '0;
		ldst_busy = 1'b0;
		ldst_valid = 1'b0;
		ldst_data = '0;
		seed = 32'h67fe58d9;
		busy_left = 0;
		resp_left = 0;
		req_count = 0;
		pass_count = 0;
		fail_count = 0;
		repeat (10) @(negedge iCLOCK);
		inRESET = 1'b1;
		@(negedge iCLOCK);
		tname = "reset";
		err = 0;
		check_val("pc_set", 0, 32'(pc_set));
		check_val("refresh", 0, 32'(refresh));
		check_val("pipeline_stop", 0, 32'(pipeline_stop));
		check_val("register_lock", 0, 32'(register_lock));
		check_val("ldst_req", 0, 32'(ldst_req));
		check_val("irq_ack", 0, 32'(irq_ack));
		report_test();
		fd = $fopen("excm_patterns.txt", "r");
		if (fd == 0) begin
			$display("cannot open the pattern file excm_patterns.txt");
			fail_count = fail_count + 1;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				nf = $fgets(line, fd);
				if (line.len() < 2 || line.getc(0) == "#") begin
					continue;
				end
				nf = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h", kind, name,
					p_jaddr, p_pcr, p_ppcr, p_idtr, p_psr, p_num, p_fi0r, p_ilock,
					p_llock, exp_pc, exp_ppcr);
				tname = string'(name);
				if (nf != 13) begin
					$display("pattern line could not be read: %0s", line);
					fail_count = fail_count + 1;
				end else begin
					run_test();
				end
			end
			$fclose(fd);
		end
		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* exception_manager.sv */
// Exception manager top level, core event and load-store ports for the pipeline
`timescale 1ns/1ps
`default_nettype none

module exception_manager import excm_pkg::*; (
	input wire iCLOCK,
	input wire inRESET,
	// Core events
	input wire jump,
	input wire word_t jump_addr,
	input wire irq_ret,
	input wire table_switch,
	// External interrupt
	input wire irq_req,
	input wire irq_num_t irq_num,
	input wire word_t irq_fi0r,
	input wire irq_lock,
	input wire ldst_lock,
	output wire irq_ack,
	// System registers
	input wire word_t psr,
	input wire word_t pcr,
	input wire word_t ppcr_in,
	input wire word_t idtr,
	// Pipeline control
	output wire register_lock,
	output wire pipeline_stop,
	output wire refresh,
	output wire pc_set,
	output wire word_t pc,
	output wire ppcr_set,
	output wire word_t ppcr,
	output wire fi0r_set,
	output wire word_t fi0r,
	output wire set_irq_mode,
	output wire clr_irq_mode,
	output wire cache_flush,
	output wire tlb_flush,
	// Load-store port, read only
	output wire ldst_use,
	output wire ldst_req,
	input wire ldst_busy,
	output wire word_t ldst_addr,
	input wire ldst_valid,
	input wire word_t ldst_data
);

	idt_fetch_if fetch0 ();

	exception_sequencer seq0 (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.fetch(fetch0),
		.jump(jump),
		.jump_addr(jump_addr),
		.irq_ret(irq_ret),
		.table_switch(table_switch),
		.irq_req(irq_req),
		.irq_num(irq_num),
		.irq_fi0r(irq_fi0r),
		.irq_lock(irq_lock),
		.ldst_lock(ldst_lock),
		.psr(psr),
		.pcr(pcr),
		.ppcr_in(ppcr_in),
		.idtr(idtr),
		.ldst_use(ldst_use),
		.register_lock(register_lock),
		.pipeline_stop(pipeline_stop),
		.refresh(refresh),
		.pc_set(pc_set),
		.pc(pc),
		.ppcr_set(ppcr_set),
		.ppcr(ppcr),
		.fi0r_set(fi0r_set),
		.fi0r(fi0r),
		.set_irq_mode(set_irq_mode),
		.clr_irq_mode(clr_irq_mode),
		.cache_flush(cache_flush),
		.tlb_flush(tlb_flush),
		.irq_ack(irq_ack)
	);

	idt_vector_reader rd0 (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.fetch(fetch0),
		.ldst_req(ldst_req),
		.ldst_busy(ldst_busy),
		.ldst_addr(ldst_addr),
		.ldst_valid(ldst_valid),
		.ldst_data(ldst_data)
	);

endmodule

`default_nettype wire

/* exception_sequencer.sv */
// Event sequencer of the exception manager, drives PC, IRQ mode and flush controls
`timescale 1ns/1ps
`default_nettype none

`include "excm_params.svh"

module exception_sequencer import excm_pkg::*; (
	input wire iCLOCK,
	input wire inRESET,
	idt_fetch_if.requester fetch,
	// Core events
	input wire jump,
	input wire word_t jump_addr,
	input wire irq_ret,
	input wire table_switch,
	// External interrupt
	input wire irq_req,
	input wire irq_num_t irq_num,
	input wire word_t irq_fi0r,
	input wire irq_lock,
	input wire ldst_lock,
	// System registers
	input wire word_t psr,
	input wire word_t pcr,
	input wire word_t ppcr_in,
	input wire word_t idtr,
	// Pipeline control
	output logic ldst_use,
	output logic register_lock,
	output logic pipeline_stop,
	output logic refresh,
	output logic pc_set,
	output word_t pc,
	output logic ppcr_set,
	output word_t ppcr,
	output logic fi0r_set,
	output word_t fi0r,
	output logic set_irq_mode,
	output logic clr_irq_mode,
	output logic cache_flush,
	output logic tlb_flush,
	output logic irq_ack
);

	seq_state_t state;
	// Interrupt accepted together with a jump
	logic irq_pend;
	logic req_q;
	logic read_open;
	word_t jump_addr_q;
	word_t ppcr_snap;
	word_t idtr_snap;
	irq_num_t irq_num_q;
	logic irq_ok;
	logic irq_with_jump;

	// Interrupt taken alone in IDLE
	assign irq_ok = irq_req && !irq_lock && psr[`EXCM_PSR_IRQ_EN_BIT];
	// Interrupt taken behind a jump
	assign irq_with_jump = irq_req && !ldst_lock && psr[`EXCM_PSR_IRQ_EN_BIT];

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= IDLE;
			irq_pend <= 1'b0;
			req_q <= 1'b0;
			read_open <= 1'b0;
			refresh <= 1'b0;
			pc_set <= 1'b0;
			ppcr_set <= 1'b0;
			fi0r_set <= 1'b0;
			set_irq_mode <= 1'b0;
			clr_irq_mode <= 1'b0;
			cache_flush <= 1'b0;
			tlb_flush <= 1'b0;
			irq_ack <= 1'b0;
		end else begin
			// All strobes fall back after one cycle
			refresh <= 1'b0;
			pc_set <= 1'b0;
			ppcr_set <= 1'b0;
			fi0r_set <= 1'b0;
			set_irq_mode <= 1'b0;
			clr_irq_mode <= 1'b0;
			cache_flush <= 1'b0;
			tlb_flush <= 1'b0;
			irq_ack <= 1'b0;
			req_q <= 1'b0;
			if (fetch.done) begin
				read_open <= 1'b0;
			end else if (req_q) begin
				read_open <= 1'b1;
			end
			case (state)
				IDLE: begin
					if (jump) begin
						state <= JUMP;
						refresh <= 1'b1;
						irq_pend <= irq_with_jump;
					end else if (irq_ok) begin
						state <= IRQ_ENTRY_REQ;
						refresh <= 1'b1;
						ppcr_set <= 1'b1;
						set_irq_mode <= 1'b1;
					end else if (table_switch) begin
						// Page directory or PSR change, reload the pipeline
						state <= TABLE_SWITCH;
						refresh <= 1'b1;
					end else if (irq_ret) begin
						state <= IRQ_RETURN;
						refresh <= 1'b1;
						cache_flush <= 1'b1;
						tlb_flush <= 1'b1;
					end
				end
				JUMP: begin
					irq_pend <= 1'b0;
					if (irq_pend) begin
						// The jump target becomes the return address
						state <= IRQ_ENTRY_REQ;
						ppcr_set <= 1'b1;
						set_irq_mode <= 1'b1;
					end else begin
						state <= IDLE;
						pc_set <= 1'b1;
					end
				end
				IRQ_ENTRY_REQ: begin
					req_q <= 1'b1;
					state <= IRQ_ENTRY_WAIT;
				end
				IRQ_ENTRY_WAIT: begin
					if (fetch.done) begin
						state <= IRQ_ENTRY_JUMP;
					end
				end
				IRQ_ENTRY_JUMP: begin
					state <= IDLE;
					pc_set <= 1'b1;
					irq_ack <= 1'b1;
					fi0r_set <= 1'b1;
				end
				IRQ_RETURN: begin
					state <= IDLE;
					pc_set <= 1'b1;
					clr_irq_mode <= 1'b1;
				end
				TABLE_SWITCH: begin
					state <= IDLE;
					pc_set <= 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Event payload
	always_ff @(posedge iCLOCK) begin
		case (state)
			IDLE: begin
				ppcr_snap <= ppcr_in;
				idtr_snap <= idtr;
				if (jump || table_switch) begin
					jump_addr_q <= jump_addr;
				end
				if (jump || irq_ok) begin
					irq_num_q <= irq_num;
					fi0r <= irq_fi0r;
				end
				if (!jump && irq_ok) begin
					ppcr <= pcr;
				end
			end
			JUMP: begin
				ppcr <= jump_addr_q;
				pc <= jump_addr_q;
			end
			IRQ_ENTRY_WAIT: begin
				if (fetch.done) begin
					pc <= fetch.vector;
				end
			end
			IRQ_RETURN: pc <= ppcr_snap;
			TABLE_SWITCH: pc <= jump_addr_q;
			default: ;
		endcase
	end

	assign fetch.req = req_q;
	// Snapshots stay put outside IDLE, so the read sees stable values
	assign fetch.idtr = idtr_snap;
	assign fetch.irq_num = irq_num_q;

	assign ldst_use = (state != IDLE);
	assign pipeline_stop = (state != IDLE) || (!jump && irq_ok);
	assign register_lock = pipeline_stop || refresh || pc_set;

	a_pc_vs_mode: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(pc_set && set_irq_mode))
		else $error("sequencer: pc_set and set_irq_mode together");

	// One descriptor read at a time
	a_single_read: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		req_q |-> !read_open)
		else $error("sequencer: fetch request while a read is open");

endmodule

`default_nettype wire

/* idt_vector_reader.sv */
// Fetches one interrupt handler address from the descriptor table over the load-store port
`timescale 1ns/1ps
`default_nettype none

`include "excm_params.svh"

module idt_vector_reader import excm_pkg::*; (
	input wire iCLOCK,
	input wire inRESET,
	idt_fetch_if.server fetch,
	output logic ldst_req,
	input wire ldst_busy,
	output word_t ldst_addr,
	input wire ldst_valid,
	input wire word_t ldst_data
);

	typedef enum logic {
		RD_WAIT = 1'b0,
		RD_LOAD = 1'b1
	} rd_state_t;

	rd_state_t state;
	// Request not yet taken by the port
	logic pend;
	logic done_q;
	word_t addr_q;
	word_t vector_q;
	word_t handler_addr;

	// Base + number * entry size + handler offset
	assign handler_addr = fetch.idtr
		+ word_t'(fetch.irq_num) * word_t'(`EXCM_IDT_ENTRY_BYTES)
		+ word_t'(`EXCM_IDT_HANDLER_OFS);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= RD_WAIT;
			pend <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				RD_WAIT: begin
					if (fetch.req) begin
						state <= RD_LOAD;
						pend <= 1'b1;
					end
				end
				RD_LOAD: begin
					if (ldst_req) begin
						pend <= 1'b0;
					end else if (!pend && ldst_valid) begin
						done_q <= 1'b1;
						state <= RD_WAIT;
					end
				end
				default: state <= RD_WAIT;
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (state == RD_WAIT && fetch.req) begin
			addr_q <= handler_addr;
		end
		if (state == RD_LOAD && !pend && ldst_valid) begin
			vector_q <= ldst_data;
		end
	end

	// Held back by the port while it is busy
	assign ldst_req = (state == RD_LOAD) && pend && !ldst_busy;
	assign ldst_addr = addr_q;
	assign fetch.done = done_q;
	assign fetch.vector = vector_q;

	a_done_open: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		fetch.done |-> $past(state) == RD_LOAD)
		else $error("vector reader: done without an open read");

	// Sent only when the port is free and sent once
	a_req_once: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		ldst_req |-> !ldst_busy ##1 !ldst_req)
		else $error("vector reader: load-store request while busy or repeated");

endmodule

`default_nettype wire

/* idt_fetch_if.sv */
// Descriptor table read channel between the exception sequencer and the vector reader
`timescale 1ns/1ps
`default_nettype none

interface idt_fetch_if import excm_pkg::*;;

	// Start of one read, single cycle
	logic req;
	// Held by the requester until done
	word_t idtr;
	irq_num_t irq_num;
	// End of the read, vector valid with it
	logic done;
	word_t vector;

	modport requester (
		output req,
		output idtr,
		output irq_num,
		input done,
		input vector
	);

	modport server (
		input req,
		input idtr,
		input irq_num,
		output done,
		output vector
	);

endinterface

`default_nettype wire

/* excm_pkg.sv */
// Types shared by the exception manager modules, imported by every RTL module
`default_nettype none

`include "excm_params.svh"

package excm_pkg;

	// One data or address word
	typedef logic [`EXCM_DATA_W-1:0] word_t;

	// Interrupt number as delivered by the interrupt controller
	typedef logic [`EXCM_IRQ_NUM_W-1:0] irq_num_t;

	// Sequencer states
	typedef enum logic [2:0] {
		IDLE           = 3'd0,
		JUMP           = 3'd1,
		IRQ_ENTRY_REQ  = 3'd2,
		IRQ_ENTRY_WAIT = 3'd3,
		IRQ_ENTRY_JUMP = 3'd4,
		IRQ_RETURN     = 3'd5,
		TABLE_SWITCH   = 3'd6
	} seq_state_t;

endpackage

`default_nettype wire

/* excm_params.svh */
// Shared constants of the exception manager, included by the RTL and the testbench
`ifndef EXCM_PARAMS_SVH
`define EXCM_PARAMS_SVH

// Address and data word width
`define EXCM_DATA_W 32

// Interrupt number width
`define EXCM_IRQ_NUM_W 7

// One descriptor table entry in bytes
`define EXCM_IDT_ENTRY_BYTES 8

// Handler address position inside an entry
`define EXCM_IDT_HANDLER_OFS 4

// Interrupt enable bit in the PSR
`define EXCM_PSR_IRQ_EN_BIT 2

`endif
